// File: all.f
+incdir+dv
source/rom_pkg.sv
source/rom_byte_packer.sv
source/rom_region_decoder.sv
source/rom_bank_store.sv
source/rom_loader_top.sv
dv/rom_loader_tb.sv

// File: Bender.yml
package:
  name: rom_loader

sources:
  - source/rom_pkg.sv
  - source/rom_byte_packer.sv
  - source/rom_region_decoder.sv
  - source/rom_bank_store.sv
  - source/rom_loader_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/rom_loader_tb.sv

// File: dv/rom_loader_tb_table.svh
`ifndef ROM_LOADER_TB_TABLE_SVH
`define ROM_LOADER_TB_TABLE_SVH

// Entry kinds, a download or a read on one of the two ports
typedef enum logic [1:0] {
	ENT_DL,
	ENT_MAIN,
	ENT_SND
} entry_kind_e;

// Download uses addr and the low byte of value
// Reads use sel, the low bits of addr and value as the expected data
typedef struct packed {
	entry_kind_e kind;
	logic [2:0]  sel;
	dl_addr_t    addr;
	logic [15:0] value;
} entry_t;

localparam int table_len = 33;

localparam entry_t stim_table [table_len] = '{
	// One word per main bank, even byte first
	'{ENT_DL,   3'd0,      25'h008_0010, 16'h0012},
	'{ENT_DL,   3'd0,      25'h008_0011, 16'h0034},
	'{ENT_MAIN, MAIN_ROM1, 25'h000_0008, 16'h1234},
	'{ENT_DL,   3'd0,      25'h009_2468, 16'h00AB},
	'{ENT_DL,   3'd0,      25'h009_2469, 16'h00CD},
	'{ENT_MAIN, MAIN_ROM2, 25'h000_1234, 16'hABCD},
	'{ENT_DL,   3'd0,      25'h00A_0100, 16'h005A},
	'{ENT_DL,   3'd0,      25'h00A_0101, 16'h00A5},
	'{ENT_MAIN, MAIN_ROM3, 25'h000_0080, 16'h5AA5},
	'{ENT_DL,   3'd0,      25'h00A_FFFE, 16'h00C3},
	'{ENT_DL,   3'd0,      25'h00A_FFFF, 16'h003C},
	'{ENT_MAIN, MAIN_SLAP, 25'h000_3FFF, 16'hC33C},
	'{ENT_DL,   3'd0,      25'h00B_0002, 16'h0077},
	'{ENT_DL,   3'd0,      25'h00B_0003, 16'h0088},
	'{ENT_MAIN, MAIN_ROM0, 25'h000_0001, 16'h7788},
	// Sound banks, byte per location
	'{ENT_DL,   3'd0,      25'h00B_8005, 16'h009E},
	'{ENT_SND,  SND_ROM0,  25'h000_0005, 16'h009E},
	'{ENT_DL,   3'd0,      25'h00B_FFFF, 16'h0061},
	'{ENT_SND,  SND_ROM1,  25'h000_3FFF, 16'h0061},
	'{ENT_DL,   3'd0,      25'h00C_1000, 16'h00F0},
	'{ENT_SND,  SND_ROM2,  25'h000_1000, 16'h00F0},
	// Sound byte becomes the high half of the next odd main byte
	'{ENT_DL,   3'd0,      25'h00B_8006, 16'h0042},
	'{ENT_DL,   3'd0,      25'h008_0021, 16'h0099},
	'{ENT_MAIN, MAIN_ROM1, 25'h000_0010, 16'h4299},
	'{ENT_SND,  SND_ROM0,  25'h000_0006, 16'h0042},
	// Lone even byte leaves the word alone
	'{ENT_DL,   3'd0,      25'h008_0010, 16'h00EE},
	'{ENT_MAIN, MAIN_ROM1, 25'h000_0008, 16'h1234},
	// Outside every region, then NONE selects
	// Past the end of snd2, its low 14 bits alias the checked snd2 byte
	'{ENT_DL,   3'd0,      25'h00C_5000, 16'h0055},
	'{ENT_MAIN, MAIN_ROM1, 25'h000_0010, 16'h4299},
	'{ENT_MAIN, MAIN_SLAP, 25'h000_7FFF, 16'hC33C},
	'{ENT_SND,  SND_ROM2,  25'h000_1000, 16'h00F0},
	'{ENT_MAIN, MAIN_NONE, 25'h000_0008, 16'h0000},
	'{ENT_SND,  SND_NONE,  25'h000_0005, 16'h0000}
};

`endif

// File: dv/rom_loader_tb.sv
`timescale 1ns/1ps

module rom_loader_tb;

	import rom_pkg::*;

	`include "rom_loader_tb_table.svh"

	// Cycles to wait for dl_ready before giving up
	localparam int ready_timeout = 20;

	logic       clk_sys;
	logic       reset;
	logic       dl_valid;
	dl_addr_t   dl_addr;
	byte_t      dl_data;
	logic       dl_ready;
	main_sel_e  main_rd_sel;
	main_addr_t main_rd_addr;
	word_t      main_rd_data;
	snd_sel_e   snd_rd_sel;
	snd_addr_t  snd_rd_addr;
	byte_t      snd_rd_data;

	int    error_count;
	// Last byte taken by the DUT, high half of the next word
	byte_t last_byte;

	rom_loader_top i_rom_loader_top (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_valid     (dl_valid),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.dl_ready     (dl_ready),
		.main_rd_sel  (main_rd_sel),
		.main_rd_addr (main_rd_addr),
		.main_rd_data (main_rd_data),
		.snd_rd_sel   (snd_rd_sel),
		.snd_rd_addr  (snd_rd_addr),
		.snd_rd_data  (snd_rd_data)
	);

	always #4 clk_sys = ~clk_sys;

	// ##################################################
	// Helpers
	// ##################################################

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		assert (actual === expected) else begin
			$display("ERROR %0t %s expected %h actual %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	// Offer one byte and hold it until the DUT takes it
	task automatic download_byte(input dl_addr_t addr, input byte_t data);
		int waited;
		@(posedge clk_sys);
		dl_valid <= 1'b1;
		dl_addr  <= addr;
		dl_data  <= data;
		waited = 0;
		do begin
			@(posedge clk_sys);
			waited++;
			if (!dl_ready && waited >= ready_timeout) begin
				$display("Timeout: dl_ready stayed low while a byte was offered");
				$display("Finished with errors");
				$finish;
			end
		end while (!dl_ready);
		dl_valid  <= 1'b0;
		last_byte = data;
	endtask

	// Two edges let the last write land before the read is sampled
	task automatic read_main(input main_sel_e sel, input main_addr_t addr,
			input word_t expected);
		repeat (2) @(posedge clk_sys);
		main_rd_sel  <= sel;
		main_rd_addr <= addr;
		// Data follows the sampling edge
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("main_rd_data", expected, main_rd_data);
	endtask

	task automatic read_snd(input snd_sel_e sel, input snd_addr_t addr, input byte_t expected);
		repeat (2) @(posedge clk_sys);
		snd_rd_sel  <= sel;
		snd_rd_addr <= addr;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("snd_rd_data", {8'h00, expected}, {8'h00, snd_rd_data});
	endtask

	// ##################################################
	// Test sequence
	// ##################################################

	initial begin
		entry_t e;
		byte_t  b;
		word_t  rand_words [32];

		void'($urandom(32'hc593f04d));
		error_count  = 0;
		last_byte    = 8'h00;
		clk_sys      = 1'b0;
		reset        = 1'b1;
		dl_valid     = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		// Selects name real banks while reset holds the outputs at zero
		main_rd_sel  = MAIN_ROM1;
		main_rd_addr = '0;
		snd_rd_sel   = SND_ROM0;
		snd_rd_addr  = '0;

		// Ready held low for all reset cycles
		for (int i = 0; i < 8; i++) begin
			@(posedge clk_sys);
			if (i == 7) begin
				reset       <= 1'b0;
				main_rd_sel <= MAIN_NONE;
				snd_rd_sel  <= SND_NONE;
			end
			@(negedge clk_sys);
			check_value("dl_ready", 16'd0, {15'd0, dl_ready});
			check_value("main_rd_data", 16'h0000, main_rd_data);
			check_value("snd_rd_data", 16'h0000, {8'h00, snd_rd_data});
		end
		// First cycle out of reset
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("dl_ready", 16'd1, {15'd0, dl_ready});
		check_value("main_rd_data", 16'h0000, main_rd_data);
		check_value("snd_rd_data", 16'h0000, {8'h00, snd_rd_data});

		// Directed table
		for (int i = 0; i < table_len; i++) begin
			e = stim_table[i];
			case (e.kind)
				ENT_DL:   download_byte(e.addr, e.value[7:0]);
				ENT_MAIN: read_main(main_sel_e'(e.sel), e.addr[main_addr_w-1:0], e.value);
				default:  read_snd(snd_sel_e'(e.sel[1:0]), e.addr[snd_addr_w-1:0],
						e.value[7:0]);
			endcase
		end

		// Random bytes into rom3 from byte offset 4000 hex, with idle gaps
		for (int i = 0; i < 64; i++) begin
			b = byte_t'($urandom);
			repeat ($urandom_range(3, 0)) @(posedge clk_sys);
			// Odd byte closes the word with the byte taken before it
			if (i % 2 == 1) begin
				rand_words[i / 2] = {last_byte, b};
			end
			download_byte(rom3_base + 25'h000_4000 + dl_addr_t'(i), b);
		end
		for (int k = 0; k < 32; k++) begin
			read_main(MAIN_ROM3, main_addr_t'(15'h2000 + k), rand_words[k]);
		end

		$display("Errors: %0d", error_count);
		if (error_count == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: source/rom_loader_top.sv
`timescale 1ns/1ps

module rom_loader_top (
	input  logic                clk_sys,
	input  logic                reset,
	// Download stream
	input  logic                dl_valid,
	input  rom_pkg::dl_addr_t   dl_addr,
	input  rom_pkg::byte_t      dl_data,
	output logic                dl_ready,
	// Main CPU read port
	input  rom_pkg::main_sel_e  main_rd_sel,
	input  rom_pkg::main_addr_t main_rd_addr,
	output rom_pkg::word_t      main_rd_data,
	// Sound CPU read port
	input  rom_pkg::snd_sel_e   snd_rd_sel,
	input  rom_pkg::snd_addr_t  snd_rd_addr,
	output rom_pkg::byte_t      snd_rd_data
);

	import rom_pkg::*;

	// Packer to decoder
	logic       pk_valid;
	dl_addr_t   pk_addr;
	word_t      pk_word;

	// Decoder to store
	main_sel_e  wr_main_sel;
	snd_sel_e   wr_snd_sel;
	logic [main_addr_w:0] wr_addr;
	word_t      wr_data;

	rom_byte_packer i_rom_byte_packer (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.dl_valid (dl_valid),
		.dl_addr  (dl_addr),
		.dl_data  (dl_data),
		.dl_ready (dl_ready),
		.pk_valid (pk_valid),
		.pk_addr  (pk_addr),
		.pk_word  (pk_word)
	);

	rom_region_decoder i_rom_region_decoder (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.pk_valid    (pk_valid),
		.pk_addr     (pk_addr),
		.pk_word     (pk_word),
		.wr_main_sel (wr_main_sel),
		.wr_snd_sel  (wr_snd_sel),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data)
	);

	rom_bank_store i_rom_bank_store (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.wr_main_sel  (wr_main_sel),
		.wr_snd_sel   (wr_snd_sel),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.main_rd_sel  (main_rd_sel),
		.main_rd_addr (main_rd_addr),
		.main_rd_data (main_rd_data),
		.snd_rd_sel   (snd_rd_sel),
		.snd_rd_addr  (snd_rd_addr),
		.snd_rd_data  (snd_rd_data)
	);

endmodule

// File: source/rom_bank_store.sv
`timescale 1ns/1ps

module rom_bank_store (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  rom_pkg::main_sel_e           wr_main_sel,
	input  rom_pkg::snd_sel_e            wr_snd_sel,
	input  logic [rom_pkg::main_addr_w:0] wr_addr,
	input  rom_pkg::word_t               wr_data,
	input  rom_pkg::main_sel_e           main_rd_sel,
	input  rom_pkg::main_addr_t          main_rd_addr,
	output rom_pkg::word_t               main_rd_data,
	input  rom_pkg::snd_sel_e            snd_rd_sel,
	input  rom_pkg::snd_addr_t           snd_rd_addr,
	output rom_pkg::byte_t               snd_rd_data
);

	import rom_pkg::*;

	// Depths in entries
	localparam int big_words   = rom_big_bytes / 2;
	localparam int small_words = rom_small_bytes / 2;

	// ##################################################
	// ROM images
	// ##################################################

	// Main CPU word banks
	word_t rom1_mem [big_words];
	word_t rom2_mem [big_words];
	word_t rom3_mem [small_words];
	word_t slap_mem [small_words];
	word_t rom0_mem [small_words];

	// Sound CPU byte banks
	byte_t snd0_mem [snd_bytes];
	byte_t snd1_mem [snd_bytes];
	byte_t snd2_mem [snd_bytes];

	// Per bank read registers
	word_t rom1_q;
	word_t rom2_q;
	word_t rom3_q;
	word_t slap_q;
	word_t rom0_q;
	byte_t snd0_q;
	byte_t snd1_q;
	byte_t snd2_q;

	// Selects aligned with the read registers
	main_sel_e main_sel_q;
	snd_sel_e  snd_sel_q;

	// Word address of the write, byte offset drops bit 0
	main_addr_t wr_word;
	snd_addr_t  wr_byte;

	assign wr_word = wr_addr[main_addr_w:1];
	assign wr_byte = wr_addr[snd_addr_w-1:0];

	// 64 KB banks use the full word address
	always_ff @(posedge clk_sys) begin
		if (wr_main_sel == MAIN_ROM1) begin
			rom1_mem[wr_word] <= wr_data;
		end
		rom1_q <= rom1_mem[main_rd_addr];
	end

	always_ff @(posedge clk_sys) begin
		if (wr_main_sel == MAIN_ROM2) begin
			rom2_mem[wr_word] <= wr_data;
		end
		rom2_q <= rom2_mem[main_rd_addr];
	end

	// 32 KB banks ignore the top address bit
	always_ff @(posedge clk_sys) begin
		if (wr_main_sel == MAIN_ROM3) begin
			rom3_mem[wr_word[main_addr_w-2:0]] <= wr_data;
		end
		rom3_q <= rom3_mem[main_rd_addr[main_addr_w-2:0]];
	end

	always_ff @(posedge clk_sys) begin
		if (wr_main_sel == MAIN_SLAP) begin
			slap_mem[wr_word[main_addr_w-2:0]] <= wr_data;
		end
		slap_q <= slap_mem[main_rd_addr[main_addr_w-2:0]];
	end

	always_ff @(posedge clk_sys) begin
		if (wr_main_sel == MAIN_ROM0) begin
			rom0_mem[wr_word[main_addr_w-2:0]] <= wr_data;
		end
		rom0_q <= rom0_mem[main_rd_addr[main_addr_w-2:0]];
	end

	// Sound banks store the low byte of the command
	always_ff @(posedge clk_sys) begin
		if (wr_snd_sel == SND_ROM0) begin
			snd0_mem[wr_byte] <= wr_data[7:0];
		end
		snd0_q <= snd0_mem[snd_rd_addr];
	end

	always_ff @(posedge clk_sys) begin
		if (wr_snd_sel == SND_ROM1) begin
			snd1_mem[wr_byte] <= wr_data[7:0];
		end
		snd1_q <= snd1_mem[snd_rd_addr];
	end

	always_ff @(posedge clk_sys) begin
		if (wr_snd_sel == SND_ROM2) begin
			snd2_mem[wr_byte] <= wr_data[7:0];
		end
		snd2_q <= snd2_mem[snd_rd_addr];
	end

	// ##################################################
	// Read port muxes
	// ##################################################

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			main_sel_q <= MAIN_NONE;
			snd_sel_q  <= SND_NONE;
		end else begin
			main_sel_q <= main_rd_sel;
			snd_sel_q  <= snd_rd_sel;
		end
	end

	always_comb begin
		case (main_sel_q)
			MAIN_ROM0: main_rd_data = rom0_q;
			MAIN_ROM1: main_rd_data = rom1_q;
			MAIN_ROM2: main_rd_data = rom2_q;
			MAIN_ROM3: main_rd_data = rom3_q;
			MAIN_SLAP: main_rd_data = slap_q;
			default:   main_rd_data = '0;
		endcase
	end

	always_comb begin
		case (snd_sel_q)
			SND_ROM0: snd_rd_data = snd0_q;
			SND_ROM1: snd_rd_data = snd1_q;
			SND_ROM2: snd_rd_data = snd2_q;
			default:  snd_rd_data = '0;
		endcase
	end

endmodule

// File: source/rom_region_decoder.sv
`timescale 1ns/1ps

module rom_region_decoder (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  logic                         pk_valid,
	input  rom_pkg::dl_addr_t            pk_addr,
	input  rom_pkg::word_t               pk_word,
	output rom_pkg::main_sel_e           wr_main_sel,
	output rom_pkg::snd_sel_e            wr_snd_sel,
	output logic [rom_pkg::main_addr_w:0] wr_addr,
	output rom_pkg::word_t               wr_data
);

	import rom_pkg::*;

	main_sel_e main_sel_d;
	snd_sel_e  snd_sel_d;
	// Byte offset inside the hit region
	dl_addr_t  offset_d;

	// Base aligned region test
	function automatic logic in_region(dl_addr_t addr, dl_addr_t base, int unsigned size);
		return (addr >= base) && ({7'd0, addr} < {7'd0, base} + size);
	endfunction

	// ##################################################
	// Address map lookup
	// ##################################################

	always_comb begin
		main_sel_d = MAIN_NONE;
		snd_sel_d  = SND_NONE;
		offset_d   = '0;
		if (in_region(pk_addr, rom1_base, rom_big_bytes)) begin
			main_sel_d = MAIN_ROM1;
			offset_d   = pk_addr - rom1_base;
		end else if (in_region(pk_addr, rom2_base, rom_big_bytes)) begin
			main_sel_d = MAIN_ROM2;
			offset_d   = pk_addr - rom2_base;
		end else if (in_region(pk_addr, rom3_base, rom_small_bytes)) begin
			main_sel_d = MAIN_ROM3;
			offset_d   = pk_addr - rom3_base;
		end else if (in_region(pk_addr, slap_base, rom_small_bytes)) begin
			main_sel_d = MAIN_SLAP;
			offset_d   = pk_addr - slap_base;
		end else if (in_region(pk_addr, rom0_base, rom_small_bytes)) begin
			main_sel_d = MAIN_ROM0;
			offset_d   = pk_addr - rom0_base;
		end else if (in_region(pk_addr, snd0_base, snd_bytes)) begin
			snd_sel_d = SND_ROM0;
			offset_d  = pk_addr - snd0_base;
		end else if (in_region(pk_addr, snd1_base, snd_bytes)) begin
			snd_sel_d = SND_ROM1;
			offset_d  = pk_addr - snd1_base;
		end else if (in_region(pk_addr, snd2_base, snd_bytes)) begin
			snd_sel_d = SND_ROM2;
			offset_d  = pk_addr - snd2_base;
		end
		// Word banks complete on the odd byte only
		if (!pk_addr[0]) begin
			main_sel_d = MAIN_NONE;
		end
		// Idle cycles issue nothing
		if (!pk_valid) begin
			main_sel_d = MAIN_NONE;
			snd_sel_d  = SND_NONE;
		end
	end

	// ##################################################
	// Write command register
	// ##################################################

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_main_sel <= MAIN_NONE;
			wr_snd_sel  <= SND_NONE;
		end else begin
			wr_main_sel <= main_sel_d;
			wr_snd_sel  <= snd_sel_d;
		end
	end

	// Packed word goes out whole, byte banks keep its low half
	always_ff @(posedge clk_sys) begin
		wr_addr <= offset_d[main_addr_w:0];
		wr_data <= pk_word;
	end

endmodule

// File: source/rom_byte_packer.sv
`timescale 1ns/1ps

module rom_byte_packer (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             dl_valid,
	input  rom_pkg::dl_addr_t dl_addr,
	input  rom_pkg::byte_t   dl_data,
	output logic             dl_ready,
	output logic             pk_valid,
	output rom_pkg::dl_addr_t pk_addr,
	output rom_pkg::word_t   pk_word
);

	// Byte transfer on this edge
	logic accept;

	assign accept = dl_valid & dl_ready;

	// Pipeline never stalls, so ready only drops in reset
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_ready <= 1'b0;
		end else begin
			dl_ready <= 1'b1;
		end
	end

	// One stage pulse per accepted byte
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pk_valid <= 1'b0;
		end else begin
			pk_valid <= accept;
		end
	end

	// Low half keeps the last accepted byte across idle cycles
	// Shifting it up pairs it with the next byte
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pk_word <= '0;
		end else if (accept) begin
			pk_word <= {pk_word[7:0], dl_data};
		end
	end

	// Address follows its byte
	always_ff @(posedge clk_sys) begin
		if (accept) begin
			pk_addr <= dl_addr;
		end
	end

endmodule

// File: source/rom_pkg.sv
package rom_pkg;

	// ##################################################
	// Widths and basic types
	// ##################################################

	// Download byte address from the loader
	localparam int dl_addr_w = 25;
	typedef logic [dl_addr_w-1:0] dl_addr_t;

	typedef logic [7:0] byte_t;

	// Main ROM word, earlier byte in the high half
	typedef logic [15:0] word_t;

	// Main CPU word address, 64 KB banks use all bits
	localparam int main_addr_w = 15;
	typedef logic [main_addr_w-1:0] main_addr_t;

	// Sound CPU byte address
	localparam int snd_addr_w = 14;
	typedef logic [snd_addr_w-1:0] snd_addr_t;

	// ##################################################
	// Download address map
	// ##################################################

	// Main CPU program banks, interleaved as words
	localparam dl_addr_t rom1_base = 25'h008_0000;
	localparam dl_addr_t rom2_base = 25'h009_0000;
	localparam dl_addr_t rom3_base = 25'h00A_0000;
	// Slapstic ROM, kept as a plain fifth bank
	localparam dl_addr_t slap_base = 25'h00A_8000;
	// System ROM
	localparam dl_addr_t rom0_base = 25'h00B_0000;

	// Sound CPU banks, one byte per location
	localparam dl_addr_t snd0_base = 25'h00B_8000;
	localparam dl_addr_t snd1_base = 25'h00B_C000;
	localparam dl_addr_t snd2_base = 25'h00C_0000;

	// Region sizes in bytes
	localparam int unsigned rom_big_bytes   = 32'h0001_0000;
	localparam int unsigned rom_small_bytes = 32'h0000_8000;
	localparam int unsigned snd_bytes       = 32'h0000_4000;

	// ##################################################
	// Bank selects
	// ##################################################

	// Main port banks, NONE reads as zero
	typedef enum logic [2:0] {
		MAIN_NONE,
		MAIN_ROM0,
		MAIN_ROM1,
		MAIN_ROM2,
		MAIN_ROM3,
		MAIN_SLAP
	} main_sel_e;

	// Sound port banks
	typedef enum logic [1:0] {
		SND_NONE,
		SND_ROM0,
		SND_ROM1,
		SND_ROM2
	} snd_sel_e;

endpackage
